// ==== tests/fm_testdata.txt ====
# W addr data (hex) | S count dup | O slot value | C channel sum (decimal)
# O and C lines check the last sample of the S line before them
W 20 81
W 21 03
W C0 01
W B0 22
S 4 0
O 0 3
O 1 0
C 0 3
S 2 0
O 0 63
O 1 3
C 0 66
S 2 0
O 0 1020
O 1 84
C 0 1104
S 1 1
O 0 2040
O 1 192
C 0 2232
C 1 0
W 22 00
W 23 01
W A1 80
W C1 0E
W B1 28
W B0 02
S 2 0
O 0 510
O 1 60
C 0 570
S 6 0
O 2 12
O 3 52
C 1 52
S 1 0
O 0 0
O 1 0
C 0 0
O 2 56
O 3 288
C 1 288

// ==== src.f ====
hdl/fm_pkg.sv
hdl/reg_bank.sv
hdl/op_sequencer.sv
hdl/phase_gen.sv
hdl/env_gen.sv
hdl/op_combiner.sv
hdl/fm_voice_top.sv
tests/fm_voice_properties.sv
tests/fm_voice_tb.sv

// ==== Makefile ====
SRCS := $(shell grep -v '^+' src.f)

.PHONY: run clean

obj_dir/Vfm_voice_tb: src.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f src.f --top-module fm_voice_tb -o Vfm_voice_tb

run: obj_dir/Vfm_voice_tb
	@out=$$(./obj_dir/Vfm_voice_tb); \
	echo "$$out"; \
	echo "$$out" | grep -q "^Regression passed$$"

clean:
	rm -rf obj_dir

// ==== tests/fm_voice_tb.sv ====
`timescale 1ns/1ps

module fm_voice_tb;
	logic clk;
	logic rst;
	fm_pkg::reg_wr_t reg_wr;
	logic sample_en;
	fm_pkg::op_out_t op_out;
	fm_pkg::ch_out_t ch_out;
	logic sample_done;

	fm_pkg::op_out_t op_seen [fm_pkg::NUM_OPS]; // Results of the last sample
	fm_pkg::ch_out_t ch_seen [fm_pkg::NUM_CH];
	int errors;
	int timeouts;
	int checks;

	fm_voice_top fm_voice_top_i (
		.clk(clk),
		.rst(rst),
		.reg_wr(reg_wr),
		.sample_en(sample_en),
		.op_out(op_out),
		.ch_out(ch_out),
		.sample_done(sample_done)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic check_op(input string name, input fm_pkg::op_out_t exp,
			input fm_pkg::op_out_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$write("[ERROR] %s: expected strobe %b ch %0d op %0d value %0d",
				name, exp.strobe, exp.ch, exp.op, exp.value);
			$display(", got strobe %b ch %0d op %0d value %0d",
				act.strobe, act.ch, act.op, act.value);
		end
	endtask

	task automatic check_ch(input string name, input fm_pkg::ch_out_t exp,
			input fm_pkg::ch_out_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[ERROR] %s: expected strobe %b ch %0d sum %0d, got strobe %b ch %0d sum %0d",
				name, exp.strobe, exp.ch, exp.sum, act.strobe, act.ch, act.sum);
		end
	endtask

	task automatic write_reg(input logic [7:0] addr, input logic [7:0] data);
		@(posedge clk);
		reg_wr.en <= 1'b1;
		reg_wr.addr <= addr;
		reg_wr.data <= data;
		@(posedge clk);
		reg_wr <= '0;
	endtask

	// One sample_en, then watch every cycle until well past sample_done
	task automatic run_sample(input bit dup);
		int k;
		int done_at;
		int ops;
		int chs;
		k = 0;
		done_at = -1;
		ops = 0;
		chs = 0;
		for (int i = 0; i < fm_pkg::NUM_OPS; i++)
			op_seen[i] = '0;
		for (int i = 0; i < fm_pkg::NUM_CH; i++)
			ch_seen[i] = '0;
		@(posedge clk);
		sample_en <= 1'b1;
		while (done_at < 0 || k <= done_at + 12) begin
			@(posedge clk);
			sample_en <= dup && k == 4; // Lands mid-sample
			@(negedge clk);
			if (op_out.strobe) begin
				if (ops >= fm_pkg::NUM_OPS || k != fm_pkg::PIPE_LAT + fm_pkg::SLOT_GAP * ops) begin
					errors++;
					$display("Unexpected op_out strobe at cycle %0d of a sample", k);
				end else begin
					op_seen[ops] = op_out;
				end
				ops++;
			end
			if (ch_out.strobe) begin
				if (chs >= fm_pkg::NUM_CH
						|| k != fm_pkg::PIPE_LAT + fm_pkg::SLOT_GAP * (2 * chs + 1)) begin
					errors++;
					$display("Unexpected ch_out strobe at cycle %0d of a sample", k);
				end else begin
					ch_seen[chs] = ch_out;
				end
				chs++;
			end
			if (sample_done) begin
				if (done_at >= 0
						|| k != fm_pkg::PIPE_LAT + fm_pkg::SLOT_GAP * (fm_pkg::NUM_OPS - 1) + 1) begin
					errors++;
					$display("sample_done pulsed at the wrong time, cycle %0d", k);
				end
				done_at = k;
			end
			k++;
			if (done_at < 0 && k > 40) begin
				timeouts++;
				$display("Timed out waiting for sample_done");
				return;
			end
		end
		if (ops != fm_pkg::NUM_OPS || chs != fm_pkg::NUM_CH) begin
			errors++;
			$display("A sample gave %0d operator and %0d channel results", ops, chs);
		end
	endtask

	initial begin
		int fd;
		int a;
		int b;
		int lineno;
		int assert_fails;
		string line;
		string cmd;
		fm_pkg::op_out_t exp_op;
		fm_pkg::ch_out_t exp_ch;
		errors = 0;
		timeouts = 0;
		checks = 0;
		lineno = 0;
		rst = 1'b1;
		reg_wr = '0;
		sample_en = 1'b0;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		fd = $fopen("tests/fm_testdata.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("Could not open tests/fm_testdata.txt");
		end else begin
			while (timeouts == 0 && !$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				lineno++;
				if (line.len() < 2 || line.getc(0) == "#")
					continue;
				void'($sscanf(line, "%s", cmd));
				if (cmd == "W")
					void'($sscanf(line, "%s %h %h", cmd, a, b));
				else
					void'($sscanf(line, "%s %d %d", cmd, a, b));
				case (cmd)
					"W": write_reg(a[7:0], b[7:0]);
					"S": begin
						for (int i = 0; i < a && timeouts == 0; i++)
							run_sample(b != 0);
					end
					"O": begin
						exp_op.strobe = 1'b1;
						exp_op.ch = a / fm_pkg::OPS_PER_CH;
						exp_op.op = a % fm_pkg::OPS_PER_CH;
						exp_op.value = b;
						check_op($sformatf("line %0d op_out %0d", lineno, a), exp_op, op_seen[a]);
					end
					"C": begin
						exp_ch.strobe = 1'b1;
						exp_ch.ch = a;
						exp_ch.sum = b;
						check_ch($sformatf("line %0d ch_out %0d", lineno, a), exp_ch, ch_seen[a]);
					end
					default: begin
						errors++;
						$display("Unknown command on test data line %0d", lineno);
					end
				endcase
			end
			$fclose(fd);
		end
		assert_fails = fm_voice_top_i.fm_voice_properties_i.fail_cnt;
		$display("Checks %0d, errors %0d, assertion failures %0d, timeouts %0d",
			checks, errors, assert_fails, timeouts);
		if (errors == 0 && assert_fails == 0 && timeouts == 0 && checks > 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

// ==== tests/fm_voice_properties.sv ====
`timescale 1ns/1ps

module fm_voice_properties (
	input logic            clk,
	input logic            rst,
	input fm_pkg::op_out_t op_out,
	input fm_pkg::ch_out_t ch_out,
	input logic            sample_done
);
	logic [2:0] op_cnt; // op_out strobes so far in this sample
	int fail_cnt = 0; // Failed assertions

	always_ff @(posedge clk) begin
		if (rst || sample_done)
			op_cnt <= '0;
		else if (op_out.strobe)
			op_cnt <= op_cnt + 1'b1;
	end

	a_done_after_last: assert property (@(posedge clk) disable iff (rst)
		op_out.strobe && int'(op_cnt) == fm_pkg::NUM_OPS - 1 |=> sample_done)
		else begin
			fail_cnt++;
			$error("sample_done did not follow the last op_out");
		end

	a_slot_gap: assert property (@(posedge clk) disable iff (rst)
		op_out.strobe && int'(op_cnt) < fm_pkg::NUM_OPS - 1
		|-> ##(fm_pkg::SLOT_GAP) op_out.strobe)
		else begin
			fail_cnt++;
			$error("op_out strobes not evenly spaced");
		end

	a_quiet_in_reset: assert property (@(posedge clk)
		rst |=> !op_out.strobe && !ch_out.strobe && !sample_done)
		else begin
			fail_cnt++;
			$error("strobe high during reset");
		end

endmodule

bind fm_voice_top fm_voice_properties fm_voice_properties_i (
	.clk(clk),
	.rst(rst),
	.op_out(op_out),
	.ch_out(ch_out),
	.sample_done(sample_done)
);

// ==== hdl/fm_voice_top.sv ====
`timescale 1ns/1ps

module fm_voice_top (
	input  logic            clk,
	input  logic            rst,
	input  fm_pkg::reg_wr_t reg_wr,
	input  logic            sample_en,
	output fm_pkg::op_out_t op_out,
	output fm_pkg::ch_out_t ch_out,
	output logic            sample_done
);
	fm_pkg::slot_t slot;
	fm_pkg::slot_t slot_q;
	fm_pkg::op_params_t op_p;
	fm_pkg::ch_params_t ch_p;
	logic [fm_pkg::WAVE_W-1:0] index;
	logic [fm_pkg::ATTEN_W-1:0] atten;

	op_sequencer op_sequencer_i (
		.clk(clk),
		.rst(rst),
		.sample_en(sample_en),
		.slot(slot),
		.sample_done(sample_done)
	);

	reg_bank #(
		.T(fm_pkg::op_params_t),
		.DEPTH(fm_pkg::NUM_OPS),
		.GROUPS(fm_pkg::OP_GROUPS)
	) op_bank_i (
		.clk(clk),
		.rst(rst),
		.reg_wr(reg_wr),
		.slot(slot),
		.params(op_p),
		.slot_q(slot_q)
	);

	// Same delay as the operator bank, its slot copy is not needed
	reg_bank #(
		.T(fm_pkg::ch_params_t),
		.DEPTH(fm_pkg::NUM_CH),
		.GROUPS(fm_pkg::CH_GROUPS)
	) ch_bank_i (
		.clk(clk),
		.rst(rst),
		.reg_wr(reg_wr),
		.slot(slot),
		.params(ch_p),
		.slot_q()
	);

	phase_gen phase_gen_i (
		.clk(clk),
		.rst(rst),
		.slot(slot_q),
		.op_p(op_p),
		.ch_p(ch_p),
		.index(index)
	);

	env_gen env_gen_i (
		.clk(clk),
		.rst(rst),
		.slot(slot_q),
		.op_p(op_p),
		.ch_p(ch_p),
		.atten(atten)
	);

	op_combiner op_combiner_i (
		.clk(clk),
		.rst(rst),
		.slot(slot_q),
		.index(index),
		.atten(atten),
		.op_p(op_p),
		.ch_p(ch_p),
		.op_out(op_out),
		.ch_out(ch_out)
	);

endmodule

// ==== hdl/op_combiner.sv ====
`timescale 1ns/1ps

module op_combiner (
	input  logic                       clk,
	input  logic                       rst,
	input  fm_pkg::slot_t              slot,
	input  logic [fm_pkg::WAVE_W-1:0]  index,
	input  logic [fm_pkg::ATTEN_W-1:0] atten,
	input  fm_pkg::op_params_t         op_p,
	input  fm_pkg::ch_params_t         ch_p,
	output fm_pkg::op_out_t            op_out,
	output fm_pkg::ch_out_t            ch_out
);
	fm_pkg::slot_t slot_p; // Lines up with index and atten
	logic signed [fm_pkg::OP_W-1:0] op0_q [fm_pkg::NUM_CH];
	logic signed [fm_pkg::OP_W-1:0] prev;
	logic signed [fm_pkg::OP_W-1:0] mod;
	logic signed [fm_pkg::OP_W-1:0] mag_sv;
	logic signed [fm_pkg::OP_W-1:0] val;
	logic signed [fm_pkg::OP_W:0] sum;
	logic [fm_pkg::WAVE_W-1:0] idx;
	logic [7:0] pos_mag;
	logic [10:0] mag8;
	logic [10:0] mag_s;
	logic neg;
	logic second_op;

	always_comb begin
		second_op = slot_p.op[0];
		prev = op0_q[slot_p.ch]; // Last sample for op0, this sample for op1
		mod = '0;
		if (second_op) begin
			if (!ch_p.cnt)
				mod = prev >>> 1;
		end else if (ch_p.fb != '0) begin
			mod = prev >>> (4'd9 - {1'b0, ch_p.fb});
		end

		idx = index + mod[fm_pkg::WAVE_W-1:0];
		neg = idx[9];
		pos_mag = idx[8] ? ~idx[7:0] : idx[7:0]; // Falls in the second quarter
		mag8 = {pos_mag, 3'b000};
		case (op_p.ws)
			2'd1: begin
				if (neg)
					mag8 = '0; // Half wave
			end
			2'd2: mag8 = 11'd2040; // Square
			default: ;
		endcase

		mag_s = mag8 >> atten[fm_pkg::ATTEN_W-1:2];
		if (atten == fm_pkg::ATTEN_SILENT)
			mag_s = '0;
		mag_sv = {1'b0, mag_s};
		val = neg ? -mag_sv : mag_sv;

		if (ch_p.cnt)
			sum = {prev[fm_pkg::OP_W-1], prev} + {val[fm_pkg::OP_W-1], val};
		else
			sum = {val[fm_pkg::OP_W-1], val};
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			slot_p <= '0;
			op_out <= '0;
			ch_out <= '0;
			for (int i = 0; i < fm_pkg::NUM_CH; i++)
				op0_q[i] <= '0;
		end else begin
			slot_p <= slot;
			op_out.strobe <= slot_p.valid;
			ch_out.strobe <= slot_p.valid && second_op;
			if (slot_p.valid) begin
				op_out.ch <= slot_p.ch;
				op_out.op <= slot_p.op;
				op_out.value <= val;
				if (second_op) begin
					ch_out.ch <= slot_p.ch;
					ch_out.sum <= sum;
				end else begin
					op0_q[slot_p.ch] <= val;
				end
			end
		end
	end

endmodule

// ==== hdl/env_gen.sv ====
`timescale 1ns/1ps

module env_gen (
	input  logic                       clk,
	input  logic                       rst,
	input  fm_pkg::slot_t              slot,
	input  fm_pkg::op_params_t         op_p,
	input  fm_pkg::ch_params_t         ch_p,
	output logic [fm_pkg::ATTEN_W-1:0] atten
);
	logic [fm_pkg::ATTEN_W-1:0] atten_r [fm_pkg::NUM_OPS];
	logic [fm_pkg::NUM_OPS-1:0] kon_q; // Key-on seen last sample
	logic [fm_pkg::SLOT_W-1:0] n;
	logic [fm_pkg::ATTEN_W-1:0] base;
	logic [fm_pkg::ATTEN_W-1:0] next;
	logic [fm_pkg::ATTEN_W:0] up;
	logic [fm_pkg::ATTEN_W:0] floor_lim;

	always_comb begin
		n = fm_pkg::op_index(slot);
		// A fresh key-on starts the attack from silence
		base = (ch_p.kon && !kon_q[n]) ? fm_pkg::ATTEN_SILENT : atten_r[n];
		up = {1'b0, base} + (fm_pkg::ATTEN_W + 1)'(fm_pkg::ENV_STEP);
		floor_lim = {1'b0, op_p.tl} + (fm_pkg::ATTEN_W + 1)'(fm_pkg::ENV_STEP);
		if (ch_p.kon) begin
			if ({1'b0, base} >= floor_lim)
				next = base - fm_pkg::ATTEN_W'(fm_pkg::ENV_STEP);
			else
				next = op_p.tl; // Stop at total level
		end else begin
			if (up > {1'b0, fm_pkg::ATTEN_SILENT})
				next = fm_pkg::ATTEN_SILENT;
			else
				next = up[fm_pkg::ATTEN_W-1:0];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < fm_pkg::NUM_OPS; i++)
				atten_r[i] <= fm_pkg::ATTEN_SILENT;
			kon_q <= '0;
			atten <= fm_pkg::ATTEN_SILENT;
		end else if (slot.valid) begin
			atten <= atten_r[n]; // Value before this sample's step
			atten_r[n] <= next;
			kon_q[n] <= ch_p.kon;
		end
	end

endmodule

// ==== hdl/phase_gen.sv ====
`timescale 1ns/1ps

module phase_gen (
	input  logic                      clk,
	input  logic                      rst,
	input  fm_pkg::slot_t             slot,
	input  fm_pkg::op_params_t        op_p,
	input  fm_pkg::ch_params_t        ch_p,
	output logic [fm_pkg::WAVE_W-1:0] index
);
	logic [fm_pkg::PHASE_W-1:0] phase [fm_pkg::NUM_OPS];
	logic [fm_pkg::PHASE_W-1:0] base;
	logic [fm_pkg::PHASE_W-1:0] inc;
	logic [fm_pkg::SLOT_W-1:0] n;

	always_comb begin
		n = fm_pkg::op_index(slot);
		base = {{(fm_pkg::PHASE_W - 10){1'b0}}, ch_p.fnum_hi, ch_p.fnum_lo} << ch_p.block;
		if (op_p.mult == '0)
			inc = base >> 1; // Half step
		else
			inc = base * op_p.mult;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < fm_pkg::NUM_OPS; i++)
				phase[i] <= '0;
		end else if (slot.valid) begin
			phase[n] <= phase[n] + inc; // Wraps
		end
	end

	// Current phase goes out, the step applies to the next sample
	always_ff @(posedge clk) begin
		if (slot.valid)
			index <= phase[n][fm_pkg::PHASE_W-1 -: fm_pkg::WAVE_W];
	end

endmodule

// ==== hdl/op_sequencer.sv ====
`timescale 1ns/1ps

module op_sequencer (
	input  logic          clk,
	input  logic          rst,
	input  logic          sample_en,
	output fm_pkg::slot_t slot,
	output logic          sample_done
);
	logic busy;
	logic [fm_pkg::GAP_W-1:0] gap_cnt;
	logic [fm_pkg::SLOT_W-1:0] slot_idx;
	logic [fm_pkg::PIPE_LAT:0] in_flight; // Last slot moving down the pipe
	logic issue;
	logic last_slot;
	logic last_issue;

	assign issue = busy && gap_cnt == '0;
	assign last_slot = int'(slot_idx) == fm_pkg::NUM_OPS - 1;
	assign last_issue = issue && last_slot;

	always_comb begin
		slot.valid = issue;
		slot.ch = slot_idx[fm_pkg::SLOT_W-1];
		slot.op = {1'b0, slot_idx[0]};
	end

	// Walk the slots, one every SLOT_GAP cycles
	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			gap_cnt <= '0;
			slot_idx <= '0;
		end else if (!busy) begin
			gap_cnt <= '0;
			slot_idx <= '0;
			// New sample only once the previous one has drained
			if (sample_en && in_flight == '0)
				busy <= 1'b1;
		end else if (int'(gap_cnt) == fm_pkg::SLOT_GAP - 1) begin
			gap_cnt <= '0;
			if (last_slot)
				busy <= 1'b0;
			else
				slot_idx <= slot_idx + 1'b1;
		end else begin
			gap_cnt <= gap_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			in_flight <= '0;
		else
			in_flight <= {in_flight[fm_pkg::PIPE_LAT-1:0], last_issue};
	end

	assign sample_done = in_flight[fm_pkg::PIPE_LAT]; // One past the last op_out

endmodule

// ==== hdl/reg_bank.sv ====
`timescale 1ns/1ps

module reg_bank #(
	parameter type T = logic [7:0],
	parameter int DEPTH = 4,
	parameter logic [$bits(T)-1:0] GROUPS = '0
) (
	input  logic            clk,
	input  logic            rst,
	input  fm_pkg::reg_wr_t reg_wr,
	input  fm_pkg::slot_t   slot,
	output T                params,
	output fm_pkg::slot_t   slot_q
);
	T mem [DEPTH];
	logic [$clog2(DEPTH)-1:0] wr_idx;
	logic [$clog2(DEPTH)-1:0] rd_idx;

	assign wr_idx = reg_wr.addr[$clog2(DEPTH)-1:0];

	// Operator banks follow the slot, channel banks only the channel
	if (DEPTH == fm_pkg::NUM_OPS) begin : g_op_idx
		assign rd_idx = fm_pkg::op_index(slot);
	end else begin : g_ch_idx
		assign rd_idx = slot.ch;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < DEPTH; i++)
				mem[i] <= '0;
		end else if (reg_wr.en && int'(reg_wr.addr[3:0]) < DEPTH) begin
			for (int k = 0; k < $bits(T) / 8; k++) begin
				if (reg_wr.addr[7:4] == GROUPS[k*8+4 +: 4])
					mem[wr_idx][k*8 +: 8] <= reg_wr.data;
			end
		end
	end

	// Params hold between slots so later stages can still see them
	always_ff @(posedge clk) begin
		if (slot.valid)
			params <= mem[rd_idx];
	end

	always_ff @(posedge clk) begin
		if (rst)
			slot_q <= '0;
		else
			slot_q <= slot;
	end

endmodule

// ==== hdl/fm_pkg.sv ====
package fm_pkg;

	// Slot geometry
	localparam int NUM_CH = 2;
	localparam int OPS_PER_CH = 2;
	localparam int NUM_OPS = NUM_CH * OPS_PER_CH;
	localparam int CH_W = $clog2(NUM_CH);
	localparam int SLOT_W = $clog2(NUM_OPS);

	localparam int OP_W = 12; // Signed operator value
	localparam int PHASE_W = 19;
	localparam int WAVE_W = 10; // Top bits of the phase
	localparam int ATTEN_W = 6;
	localparam logic [ATTEN_W-1:0] ATTEN_SILENT = 6'd63;
	localparam int ENV_STEP = 8; // Attenuation change per sample

	localparam int SLOT_GAP = 2;
	localparam int GAP_W = $clog2(SLOT_GAP);
	localparam int PIPE_LAT = 3; // Slot issue to op_out

	// One group base per payload byte, byte 0 in the low bits
	localparam logic [15:0] OP_GROUPS = {8'h40, 8'h20};
	localparam logic [23:0] CH_GROUPS = {8'hC0, 8'hB0, 8'hA0};

	typedef struct packed {
		logic en;
		logic [7:0] addr;
		logic [7:0] data;
	} reg_wr_t;

	typedef struct packed {
		logic [1:0] rsvd_tl; // 0x40
		logic [5:0] tl;
		logic [1:0] ws; // 0x20
		logic [1:0] rsvd_mult;
		logic [3:0] mult;
	} op_params_t;

	typedef struct packed {
		logic [3:0] rsvd_c; // 0xC0
		logic [2:0] fb;
		logic cnt;
		logic [1:0] rsvd_b; // 0xB0
		logic kon;
		logic [2:0] block;
		logic [1:0] fnum_hi;
		logic [7:0] fnum_lo; // 0xA0
	} ch_params_t;

	typedef struct packed {
		logic valid;
		logic [CH_W-1:0] ch;
		logic [1:0] op; // Operator within the channel
	} slot_t;

	typedef struct packed {
		logic strobe;
		logic [CH_W-1:0] ch;
		logic [1:0] op;
		logic signed [OP_W-1:0] value;
	} op_out_t;

	typedef struct packed {
		logic strobe;
		logic [CH_W-1:0] ch;
		logic signed [OP_W:0] sum;
	} ch_out_t;

	// Flat operator number of a slot
	function automatic logic [SLOT_W-1:0] op_index(slot_t s);
		return SLOT_W'(int'(s.ch) * OPS_PER_CH + int'(s.op));
	endfunction

endpackage
